// File: source/iduPkg.sv
// instruction decode shared types
`default_nettype none

package iduPkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int InsnWidth   = 32;     // one alpha insn word
  localparam int RegNumWidth = 5;      // 32 integer regs
  localparam int PcWidth     = 64;     // latched pc field

  localparam logic [RegNumWidth-1:0] ZeroReg = 5'd31;  // r31 reads as zero

  // ----------------------------------------
  // field types
  // ----------------------------------------
  typedef logic [5:0] opcodeT;   // insn bits 31:26
  typedef logic [6:0] fctT;      // operate function code

  typedef struct packed {
    logic                   valid;
    logic [RegNumWidth-1:0] num;
  } regRefT;

  typedef struct packed {
    logic        valid;
    logic [20:0] value;   // literal or displacement
  } constT;

  // operate format, literal sits in rb and litLo
  typedef struct packed {
    opcodeT                 opcode;
    logic [RegNumWidth-1:0] ra;
    logic [RegNumWidth-1:0] rb;    // upper literal bits when litFlag set
    logic [2:0]             litLo; // insn 15:13
    logic                   litFlag;
    fctT                    fct;
    logic [RegNumWidth-1:0] rc;
  } operateT;

  // memory format, jmp hint is disp 15:14
  typedef struct packed {
    opcodeT                 opcode;
    logic [RegNumWidth-1:0] ra;
    logic [RegNumWidth-1:0] rb;
    logic [15:0]            disp;
  } memoryT;

  // branch format, displacement takes the rest of the word
  typedef struct packed {
    opcodeT                                           opcode;
    logic [RegNumWidth-1:0]                           ra;
    logic [InsnWidth-$bits(opcodeT)-RegNumWidth-1:0]  disp;
  } branchT;

  typedef union packed {
    operateT operate;
    memoryT  memory;
    branchT  branch;
  } insnU;

  // decoded class bits, horizontal then vertical
  typedef struct packed {
    logic alu;
    logic mem;
    logic ctr;
    logic aluMult;
    logic memSt;
    logic memQw;
    logic memAcc;
    logic ctrCond;
    logic ctrPc;
  } decodeT;

  typedef enum logic [2:0] {ExcNone, ExcPal, ExcResv, ExcFp, ExcLdLstC} excT;

  typedef struct packed {
    logic               work;   // 0 means bubble
    insnU               insn;
    logic [PcWidth-1:0] pc;     // pc+4 of this insn
  } stageT;

  // ----------------------------------------
  // opcodes
  // ----------------------------------------
  localparam opcodeT OpLda  = 6'h08, OpLdah = 6'h09, OpLdqU = 6'h0B, OpStqU = 6'h0F;
  localparam opcodeT OpIntA = 6'h10, OpIntL = 6'h11, OpIntS = 6'h12, OpIntM = 6'h13;
  localparam opcodeT OpJmp  = 6'h1A;
  localparam opcodeT OpLdl  = 6'h28, OpLdq  = 6'h29, OpLdlL = 6'h2A, OpLdqL = 6'h2B;
  localparam opcodeT OpStl  = 6'h2C, OpStq  = 6'h2D, OpStlC = 6'h2E, OpStqC = 6'h2F;
  localparam opcodeT OpBr   = 6'h30, OpBsr  = 6'h34;
  localparam opcodeT OpBlbc = 6'h38, OpBeq  = 6'h39, OpBlt  = 6'h3A, OpBle  = 6'h3B;
  localparam opcodeT OpBlbs = 6'h3C, OpBne  = 6'h3D, OpBge  = 6'h3E, OpBgt  = 6'h3F;

endpackage

`default_nettype wire

// File: source/iduStage.sv
// decode pipeline latch
`timescale 1ns/1ps
`default_nettype none

module iduStage #(
  parameter int PcWidth = 64
) (
  input  wire logic               Clk,
  input  wire logic               rstN,
  input  wire logic               Step,    // advance insn and pc
  input  wire logic               Work,    // valid op or bubble
  input  wire iduPkg::insnU       Insn,
  input  wire logic [PcWidth-1:0] Pc,      // pc+4 from fetch
  output iduPkg::stageT           stage
);

  logic [$bits(stage.pc)-1:0] pcExt;  // pc widened to the stage field

  // zero fill above PcWidth
  always_comb begin
    pcExt = '0;
    pcExt[PcWidth-1:0] = Pc;
  end

  // ----------------------------------------
  // latch
  // ----------------------------------------
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      stage <= '0;                 // purge stage
    end else begin
      stage.work <= Work;          // work follows every edge
      if (Step) begin
        stage.insn <= Insn;
        stage.pc   <= pcExt;
      end
      // no step, insn and pc hold
    end
  end

endmodule

`default_nettype wire

// File: source/opClassify.sv
// opcode classifier and decode bits
`timescale 1ns/1ps
`default_nettype none

module opClassify (
  input  wire iduPkg::stageT  stage,
  output iduPkg::opcodeT      OpCode,
  output iduPkg::decodeT      dec,
  output iduPkg::excT         Exception
);

  import iduPkg::*;

  // opcode always at 31:26, no mux
  assign OpCode = stage.insn.operate.opcode;

  // ----------------------------------------
  // exception class
  // ----------------------------------------
  // items listed in priority order
  always_comb begin
    Exception = ExcNone;
    if (stage.work) begin
      case (OpCode) inside
        6'h00, 6'h19, 6'h1B,
        6'h1D, 6'h1E, 6'h1F:           Exception = ExcPal;   // pal and reserved pal
        [6'h01:6'h07], 6'h0A, 6'h0C,
        6'h0D, 6'h0E, 6'h14, 6'h1C:    Exception = ExcResv;
        6'h15, 6'h16, 6'h17,
        [6'h20:6'h27],                                       // fp load/store
        6'h31, 6'h32, 6'h33,
        6'h35, 6'h36, 6'h37:           Exception = ExcFp;
        OpLdlL, OpLdqL,
        OpStlC, OpStqC:                Exception = ExcLdLstC;
        default:                       Exception = ExcNone;
      endcase
    end
  end

  // ----------------------------------------
  // decode bits
  // ----------------------------------------
  always_comb begin
    dec = '0;

    // horizontal, one bit per class
    case (OpCode)
      OpIntA, OpIntL,
      OpIntS, OpIntM:  dec.alu = 1'b1;
      OpLda, OpLdah,
      OpLdl, OpLdq,
      OpLdlL, OpLdqL,
      OpLdqU,
      OpStl, OpStq,
      OpStlC, OpStqC,
      OpStqU:          dec.mem = 1'b1;
      OpBlbc, OpBeq,
      OpBlt, OpBle,
      OpBlbs, OpBne,
      OpBge, OpBgt,
      OpBr, OpBsr,
      OpJmp:           dec.ctr = 1'b1;
      default:         ;
    endcase

    // vertical bits
    case (OpCode)
      OpIntM:          dec.aluMult = 1'b1;
      OpStl, OpStq,
      OpStlC, OpStqC,
      OpStqU:          dec.memSt = 1'b1;
      default:         ;
    endcase

    case (OpCode)
      OpLda, OpLdah,
      OpLdq, OpLdqL,
      OpLdqU,
      OpStq, OpStqC,
      OpStqU:          dec.memQw = 1'b1;   // quadword access
      OpBlbc, OpBeq,
      OpBlt, OpBle,
      OpBlbs, OpBne,
      OpBge, OpBgt:    begin
        dec.ctrCond = 1'b1;
        dec.ctrPc   = 1'b1;
      end
      OpBr, OpBsr:     dec.ctrPc = 1'b1;    // pc relative, no condition
      default:         ;
    endcase

    // lda/ldah only compute an address
    dec.memAcc = dec.mem & (OpCode != OpLda) & (OpCode != OpLdah);

    if (!stage.work) begin
      dec = '0;   // bubble decodes to nothing
    end
  end

endmodule

`default_nettype wire

// File: source/regSelect.sv
// source and destination register select
`timescale 1ns/1ps
`default_nettype none

module regSelect (
  input  wire iduPkg::stageT   stage,
  input  wire iduPkg::decodeT  dec,
  output iduPkg::regRefT       RegA,     // to reg file
  output iduPkg::regRefT       RegB,     // to reg file
  output iduPkg::regRefT       RegDest
);

  import iduPkg::*;

  logic                   isLoad;       // mem without store
  logic                   isUncondCtr;  // br, bsr, jmp
  logic                   noRegB;
  logic                   destHit;      // insn writes a register
  logic [RegNumWidth-1:0] destNum;

  assign isLoad      = dec.mem & ~dec.memSt;
  assign isUncondCtr = dec.ctr & ~dec.ctrCond;
  // branch format or operate literal form
  assign noRegB      = (dec.ctr & dec.ctrPc) | (dec.alu & stage.insn.operate.litFlag);

  // ----------------------------------------
  // sources
  // ----------------------------------------
  always_comb begin
    RegA.num   = stage.insn.operate.ra;   // ra always encoded
    RegA.valid = stage.work & ~(isUncondCtr | isLoad);   // ra is dest here
    RegB.num   = stage.insn.operate.rb;
    RegB.valid = stage.work & ~noRegB;
  end

  // ----------------------------------------
  // destination
  // ----------------------------------------
  always_comb begin
    destNum = '0;
    destHit = 1'b0;
    if (dec.alu) begin
      destNum = stage.insn.operate.rc;      // operate writes rc
      destHit = 1'b1;
    end else if (isLoad | isUncondCtr) begin
      destNum = stage.insn.operate.ra;      // loads and link reg use ra
      destHit = 1'b1;
    end
  end

  // r31 dest counts as no dest
  always_comb begin
    RegDest.num   = destNum;
    RegDest.valid = stage.work & destHit & (destNum != ZeroReg);
  end

endmodule

`default_nettype wire

// File: source/immSelect.sv
// function code, constant and operand muxes
`timescale 1ns/1ps
`default_nettype none

module immSelect #(
  parameter int DataWidth = 64,
  parameter int PcWidth   = 64
) (
  input  wire iduPkg::stageT         stage,
  input  wire iduPkg::decodeT        dec,
  input  wire logic [DataWidth-1:0]  RegAValue,   // same cycle from reg file
  input  wire logic [DataWidth-1:0]  RegBValue,
  output iduPkg::fctT                FctCode,
  output iduPkg::constT              Const,
  output logic [DataWidth-1:0]       Operand1,
  output logic [DataWidth-1:0]       Operand2
);

  import iduPkg::*;

  logic [DataWidth-1:0] pcOperand;   // latched pc, zero extended

  always_comb begin
    pcOperand = '0;
    pcOperand[PcWidth-1:0] = stage.pc[PcWidth-1:0];
  end

  // jmp carries its hint where others have fct
  assign FctCode = (dec.ctr & ~dec.ctrPc) ? fctT'(stage.insn.memory.disp[15:14])
                                          : stage.insn.operate.fct;

  // ----------------------------------------
  // constant bus
  // ----------------------------------------
  always_comb begin
    Const = '0;
    if (dec.alu) begin
      if (stage.insn.operate.litFlag) begin
        Const.valid = 1'b1;
        // 8 bit literal, zero extended
        Const.value = {13'b0, stage.insn.operate.rb, stage.insn.operate.litLo};
      end
    end else if (dec.mem) begin
      Const.valid = 1'b1;
      Const.value = {{5{stage.insn.memory.disp[15]}}, stage.insn.memory.disp};  // sign ext
    end else if (dec.ctr & dec.ctrPc) begin
      Const.valid = 1'b1;
      Const.value = stage.insn.branch.disp;   // full 21 bit disp
    end
  end

  // ----------------------------------------
  // operand buses
  // ----------------------------------------
  always_comb begin
    Operand1 = RegAValue;
    Operand2 = RegBValue;
    if (dec.ctr) begin
      if (dec.ctrCond) begin
        Operand2 = pcOperand;    // ra tested, pc for target
      end else begin
        Operand1 = pcOperand;    // link value
      end
    end
  end

endmodule

`default_nettype wire

// File: source/idu.sv
// instruction decode unit top
`timescale 1ns/1ps
`default_nettype none

module idu #(
  parameter int DataWidth = 64,
  parameter int PcWidth   = 64
) (
  input  wire logic                 Clk,
  input  wire logic                 rstN,
  input  wire logic                 Step,
  input  wire logic                 Work,
  input  wire iduPkg::insnU         Insn,
  input  wire logic [PcWidth-1:0]   Pc,
  input  wire logic [DataWidth-1:0] RegAValue,
  input  wire logic [DataWidth-1:0] RegBValue,
  output iduPkg::regRefT            RegA,
  output iduPkg::regRefT            RegB,
  output iduPkg::regRefT            RegDest,
  output iduPkg::constT             Const,
  output iduPkg::opcodeT            OpCode,
  output iduPkg::fctT               FctCode,
  output iduPkg::decodeT            Dec,
  output iduPkg::excT               Exception,
  output logic [DataWidth-1:0]      Operand1,
  output logic [DataWidth-1:0]      Operand2
);

  import iduPkg::*;

  stageT  stage;   // latched work, insn, pc

  iduStage #(.PcWidth(PcWidth)) uStage (
    .Clk, .rstN, .Step, .Work, .Insn, .Pc,
    .stage (stage)
  );

  opClassify uClassify (
    .stage (stage), .OpCode, .dec (Dec), .Exception
  );

  // reg numbers go out before values come back
  regSelect uRegSel (
    .stage (stage), .dec (Dec), .RegA, .RegB, .RegDest
  );

  immSelect #(.DataWidth(DataWidth), .PcWidth(PcWidth)) uImmSel (
    .stage (stage), .dec (Dec), .RegAValue, .RegBValue,
    .FctCode, .Const, .Operand1, .Operand2
  );

endmodule

`default_nettype wire

// File: test/iduSva_sva.sv
// decode unit property checks
`timescale 1ns/1ps
`default_nettype none

module iduSva (
  input wire logic           Clk,
  input wire logic           rstN,
  input wire logic           work,       // latched work bit
  input wire iduPkg::excT    Exception,
  input wire iduPkg::regRefT RegDest,
  input wire iduPkg::decodeT Dec
);

  import iduPkg::*;

  // ----------------------------------------
  // properties
  // ----------------------------------------
  // bubble never raises a class
  bubbleNoExc: assert property (@(posedge Clk) disable iff (!rstN)
    !work |-> Exception == ExcNone)
    else $error("exception class raised with no work latched");

  // r31 never written
  destNotZero: assert property (@(posedge Clk) disable iff (!rstN)
    RegDest.valid |-> RegDest.num != ZeroReg)
    else $error("destination valid on the zero register");

  // horizontal class bits exclusive
  oneClass: assert property (@(posedge Clk) disable iff (!rstN)
    $onehot0({Dec.alu, Dec.mem, Dec.ctr}))
    else $error("more than one instruction class decoded");

endmodule

bind idu iduSva uSva (
  .Clk       (Clk),
  .rstN      (rstN),
  .work      (stage.work),
  .Exception (Exception),
  .RegDest   (RegDest),
  .Dec       (Dec)
);

`default_nettype wire

// File: test/iduTb.sv
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module iduTb;

  import iduPkg::*;

  localparam int DataWidth     = 64;
  localparam int PcWidth       = 64;
  localparam int NumCycles     = 3000;
  localparam int TimeoutCycles = NumCycles + 200;   // reset plus slack

  // opcodes that decode to a class
  localparam logic [5:0] TableOps [27] = '{
    6'h08, 6'h09, 6'h0B, 6'h0F, 6'h10, 6'h11, 6'h12, 6'h13, 6'h1A,
    6'h28, 6'h29, 6'h2A, 6'h2B, 6'h2C, 6'h2D, 6'h2E, 6'h2F,
    6'h30, 6'h34, 6'h38, 6'h39, 6'h3A, 6'h3B, 6'h3C, 6'h3D, 6'h3E, 6'h3F
  };

  logic                 Clk = 1'b0;
  logic                 rstN;
  logic                 Step;
  logic                 Work;
  insnU                 Insn;
  logic [PcWidth-1:0]   Pc;
  logic [DataWidth-1:0] RegAValue;
  logic [DataWidth-1:0] RegBValue;
  regRefT               RegA;
  regRefT               RegB;
  regRefT               RegDest;
  constT                Const;
  opcodeT               OpCode;
  fctT                  FctCode;
  decodeT               Dec;
  excT                  Exception;
  logic [DataWidth-1:0] Operand1;
  logic [DataWidth-1:0] Operand2;

  integer               seed;
  int                   cycleCount = 0;
  logic                 mWork;        // model copy of the latch
  logic [31:0]          mInsn;
  logic [PcWidth-1:0]   mPc;

  idu #(.DataWidth(DataWidth), .PcWidth(PcWidth)) u_dut (
    .Clk, .rstN, .Step, .Work, .Insn, .Pc, .RegAValue, .RegBValue,
    .RegA, .RegB, .RegDest, .Const, .OpCode, .FctCode, .Dec, .Exception,
    .Operand1, .Operand2
  );

  always #4 Clk = ~Clk;   // 8 ns period

  // ----------------------------------------
  // failure and timeout
  // ----------------------------------------
  task automatic abortRun(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abortRun("output mismatch");
    end
  endtask

  always @(posedge Clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      abortRun("run did not finish within the cycle limit");
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic excT modelExc(input logic w, input logic [5:0] op);
    if (!w) return ExcNone;
    if (op inside {6'h00, 6'h19, 6'h1B, 6'h1D, 6'h1E, 6'h1F}) return ExcPal;
    if (op inside {[6'h01:6'h07], 6'h0A, 6'h0C, 6'h0D, 6'h0E, 6'h14, 6'h1C}) return ExcResv;
    if (op inside {6'h15, 6'h16, 6'h17, [6'h20:6'h27], 6'h31, 6'h32, 6'h33,
                   6'h35, 6'h36, 6'h37}) return ExcFp;
    if (op inside {6'h2A, 6'h2B, 6'h2E, 6'h2F}) return ExcLdLstC;
    return ExcNone;
  endfunction

  function automatic decodeT modelDec(input logic w, input logic [5:0] op);
    decodeT d;
    d         = '0;
    d.ctrCond = (op[5:3] == 3'b111);                     // 38..3f
    d.ctrPc   = d.ctrCond | (op == 6'h30) | (op == 6'h34);
    d.ctr     = d.ctrPc | (op == 6'h1A);
    d.alu     = op inside {[6'h10:6'h13]};
    d.aluMult = (op == 6'h13);
    d.memSt   = op inside {6'h0F, [6'h2C:6'h2F]};
    d.mem     = d.memSt | (op inside {6'h08, 6'h09, 6'h0B, [6'h28:6'h2B]});
    d.memQw   = op inside {6'h08, 6'h09, 6'h0B, 6'h0F, 6'h29, 6'h2B, 6'h2D, 6'h2F};
    d.memAcc  = d.mem & ~(op inside {6'h08, 6'h09});    // lda, ldah only add
    if (!w) d = '0;
    return d;
  endfunction

  task automatic checkOutputs();
    decodeT               d;
    regRefT               expA, expB, expDest;
    constT                expConst;
    logic [6:0]           expFct;
    logic [DataWidth-1:0] expOp1, expOp2;
    logic                 isLoad, isUncond;
    d        = modelDec(mWork, mInsn[31:26]);
    isLoad   = d.mem & ~d.memSt;
    isUncond = d.ctr & ~d.ctrCond;
    expA     = {mWork & ~(isLoad | isUncond), mInsn[25:21]};
    expB     = {mWork & ~((d.ctr & d.ctrPc) | (d.alu & mInsn[12])), mInsn[20:16]};
    expDest  = '0;
    if (d.alu) expDest.num = mInsn[4:0];                  // rc
    else if (isLoad | isUncond) expDest.num = mInsn[25:21];
    expDest.valid = mWork & (d.alu | isLoad | isUncond) & (expDest.num != 5'd31);
    expFct   = (d.ctr & ~d.ctrPc) ? {5'b0, mInsn[15:14]} : mInsn[11:5];   // jmp hint
    expConst = '0;
    if (d.alu & mInsn[12]) expConst = {1'b1, 13'b0, mInsn[20:13]};
    else if (d.mem) expConst = {1'b1, {5{mInsn[15]}}, mInsn[15:0]};
    else if (d.ctrPc) expConst = {1'b1, mInsn[20:0]};
    expOp1 = RegAValue;
    expOp2 = RegBValue;
    if (d.ctrCond) expOp2 = mPc;         // test ra, target from pc
    else if (d.ctr) expOp1 = mPc;        // link value
    // bubble quiet check
    if (!mWork) begin
      assert (Dec == '0 && !RegA.valid && !RegB.valid && !RegDest.valid
              && Exception == ExcNone)
        else abortRun("decode outputs active while no work is latched");
    end
    checkValue("Exception", 64'(Exception), 64'(modelExc(mWork, mInsn[31:26])));
    checkValue("Dec", 64'(Dec), 64'(d));
    checkValue("OpCode", 64'(OpCode), 64'(mInsn[31:26]));
    checkValue("RegA", 64'(RegA), 64'(expA));
    checkValue("RegB", 64'(RegB), 64'(expB));
    checkValue("RegDest", 64'(RegDest), 64'(expDest));
    checkValue("FctCode", 64'(FctCode), 64'(expFct));
    checkValue("Const", 64'(Const), 64'(expConst));
    checkValue("Operand1", Operand1, expOp1);
    checkValue("Operand2", Operand2, expOp2);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic driveInputs();
    logic [31:0] r;
    logic [31:0] word;
    word = $random(seed);
    r    = $random(seed);
    if (r[0]) word[31:26] = TableOps[5'(r[31:1] % 27)];   // half from table
    Insn = word;
    r    = $random(seed);
    Work = (r % 10) < 8;      // about 80 percent
    r    = $random(seed);
    Step = (r % 10) < 8;
    Pc        = {$random(seed), $random(seed)};
    RegAValue = {$random(seed), $random(seed)};
    RegBValue = {$random(seed), $random(seed)};
    mWork = Work;             // what the next edge latches
    if (Step) begin
      mInsn = word;
      mPc   = Pc;
    end
  endtask

  initial begin
    seed      = 32'h9d85;
    rstN      = 1'b0;
    Step      = 1'b0;
    Work      = 1'b0;
    Insn      = '0;
    Pc        = '0;
    RegAValue = '0;
    RegBValue = '0;
    mWork     = 1'b0;
    mInsn     = '0;
    mPc       = '0;
    repeat (2) @(posedge Clk);
    @(negedge Clk);
    rstN = 1'b1;
    for (int i = 0; i < NumCycles; i++) begin
      checkOutputs();           // state from the last edge
      driveInputs();
      @(negedge Clk);
    end
    checkOutputs();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/iduPkg.sv
source/iduStage.sv
source/opClassify.sv
source/regSelect.sv
source/immSelect.sv
source/idu.sv
test/iduSva_sva.sv
test/iduTb.sv

// File: Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       := iduTb
FILELIST  := files.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
